// File: hw/decode_if.sv
`timescale 1ns/10ps

interface decode_if;

    rv_isa_pkg::fmt_t       fmt;
    id_ctrl_pkg::alu_op_t   alu_op;
    logic                   sgn;
    id_ctrl_pkg::br_type_t  br_type;
    logic                   is_branch;
    logic                   is_jump;
    logic                   mem_rd;
    logic                   is_store;
    logic                   rd_we;
    id_ctrl_pkg::opr1_sel_t opr1_sel;
    logic                   opr2_imm;
    logic                   uses_rs1;
    logic                   uses_rs2;

    // Decoder side drives everything
    modport dec (output fmt, alu_op, sgn, br_type, is_branch, is_jump, mem_rd,
                 is_store, rd_we, opr1_sel, opr2_imm, uses_rs1, uses_rs2);

    modport imm (input fmt);

    modport haz (input uses_rs1, uses_rs2);

    // Stage register sees all control except source usage
    modport stg (input fmt, alu_op, sgn, br_type, is_branch, is_jump, mem_rd,
                 is_store, rd_we, opr1_sel, opr2_imm);

endinterface

// File: hw/hazard_forward.sv
`timescale 1ns/10ps

module hazard_forward (
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    input  rv_isa_pkg::reg_idx_t dest_exe,
    input  rv_isa_pkg::reg_idx_t dest_mem,
    input  logic                 load_exe,
    input  rv_isa_pkg::data_t    regfile1,
    input  rv_isa_pkg::data_t    regfile2,
    input  rv_isa_pkg::data_t    exe_fwd,
    input  rv_isa_pkg::data_t    mem_fwd,
    decode_if.haz                dec,
    output rv_isa_pkg::data_t    rs1_val,
    output rv_isa_pkg::data_t    rs2_val,
    output logic                 id_hold
);

    // Index 0 is rs1, index 1 is rs2
    rv_isa_pkg::reg_idx_t src_idx [2];
    rv_isa_pkg::data_t    rf_val  [2];
    rv_isa_pkg::data_t    src_val [2];
    logic [1:0]           src_used;
    logic [1:0]           src_hold;

    assign src_idx[0] = rs1_idx;
    assign src_idx[1] = rs2_idx;
    assign rf_val[0]  = regfile1;
    assign rf_val[1]  = regfile2;
    assign src_used   = {dec.uses_rs2, dec.uses_rs1};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            // x0 is hardwired, never forwarded
            if (src_idx[s] == '0) begin
                src_val[s] = '0;
            end else if (src_idx[s] == dest_exe) begin
                // Youngest producer wins
                src_val[s] = exe_fwd;
            end else if (src_idx[s] == dest_mem) begin
                src_val[s] = mem_fwd;
            end else begin
                // Write-back matches land here, the register file writes through
                src_val[s] = rf_val[s];
            end
            // Load data only reaches MEM next cycle
            src_hold[s] = src_used[s] && (src_idx[s] != '0) &&
                          (src_idx[s] == dest_exe) && load_exe;
        end
    end

    assign rs1_val = src_val[0];
    assign rs2_val = src_val[1];
    assign id_hold = |src_hold;

endmodule

// File: hw/id_ctrl_pkg.sv
`include "id_defines.svh"

package id_ctrl_pkg;

    typedef logic [`ALU_OP_W-1:0]  alu_op_t;
    typedef logic [`BR_TYPE_W-1:0] br_type_t;
    typedef logic [1:0]            opr1_sel_t;

    // ALU codes, SUB shares the adder bit with ADD
    localparam alu_op_t ALU_ADD = 8'd1;
    localparam alu_op_t ALU_SUB = 8'd3;
    localparam alu_op_t ALU_AND = 8'd4;
    localparam alu_op_t ALU_OR  = 8'd8;
    localparam alu_op_t ALU_XOR = 8'd16;
    localparam alu_op_t ALU_SLL = 8'd32;
    localparam alu_op_t ALU_SRL = 8'd64;
    localparam alu_op_t ALU_SRA = 8'd128;

    // Bit 0 takes XOR result, bit 1 adder sign, bit 2 inverts, bit 3 is set-less-than
    localparam br_type_t BR_NONE = 4'b0000;
    localparam br_type_t BR_EQ   = 4'b0101;
    localparam br_type_t BR_NE   = 4'b0001;
    localparam br_type_t BR_LT   = 4'b0010;
    localparam br_type_t BR_GE   = 4'b0110;
    localparam br_type_t BR_SLT  = 4'b1000;

    // Operand 1 source
    localparam opr1_sel_t OPR1_RS1  = 2'd0;
    localparam opr1_sel_t OPR1_ZERO = 2'd1;
    localparam opr1_sel_t OPR1_PC   = 2'd2;

endpackage

// File: hw/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Register file index width, 32 architectural registers
`define REG_IDX_W 5

// One-hot ALU operation select
`define ALU_OP_W 8

// Branch compare control to EXE
`define BR_TYPE_W 4

`endif

// File: hw/id_pipe_reg.sv
`timescale 1ns/10ps

module id_pipe_reg (
    input  logic                    clk_stage,
    input  logic                    rst,
    input  logic                    id_buf_en,
    input  rv_isa_pkg::data_t       pc,
    input  logic                    pc_taken,
    input  rv_isa_pkg::instr_t      instr,
    input  rv_isa_pkg::data_t       imm,
    input  rv_isa_pkg::data_t       rs1_val,
    input  rv_isa_pkg::data_t       rs2_val,
    decode_if.stg                   dec,
    output rv_isa_pkg::data_t       alu_opr1,
    output rv_isa_pkg::data_t       alu_opr2,
    output rv_isa_pkg::data_t       store_src,
    output rv_isa_pkg::data_t       pc_out,
    output logic                    pc_taken_out,
    output id_ctrl_pkg::alu_op_t    alu_op,
    output logic                    sgn,
    output id_ctrl_pkg::br_type_t   br_type,
    output logic                    is_branch,
    output logic                    is_jump,
    output logic                    mem_rd_out,
    output rv_isa_pkg::reg_idx_t    rd_out
);

    rv_isa_pkg::data_t    opr1_next;
    rv_isa_pkg::data_t    opr2_next;
    rv_isa_pkg::reg_idx_t rd_next;

    // Operand 1 source
    always_comb begin
        case (dec.opr1_sel)
            id_ctrl_pkg::OPR1_ZERO: opr1_next = '0;
            id_ctrl_pkg::OPR1_PC:   opr1_next = pc;
            default:                opr1_next = rs1_val;
        endcase
    end

    // Branches compare rs1 against rs2, the target adder lives elsewhere
    assign opr2_next = dec.opr2_imm ? imm : rs2_val;

    // No destination for branches and stores
    assign rd_next = dec.rd_we ? instr[11:7] : '0;

    always_ff @(posedge clk_stage or negedge rst) begin
        if (!rst) begin
            alu_opr1     <= '0;
            alu_opr2     <= '0;
            pc_out       <= '0;
            pc_taken_out <= 1'b0;
            alu_op       <= '0;
            sgn          <= 1'b0;
            br_type      <= '0;
            is_branch    <= 1'b0;
            is_jump      <= 1'b0;
            mem_rd_out   <= 1'b0;
            rd_out       <= '0;
        end else if (id_buf_en) begin
            alu_opr1     <= opr1_next;
            alu_opr2     <= opr2_next;
            pc_out       <= pc;
            pc_taken_out <= pc_taken;
            alu_op       <= dec.alu_op;
            sgn          <= dec.sgn;
            br_type      <= dec.br_type;
            is_branch    <= dec.is_branch;
            is_jump      <= dec.is_jump;
            mem_rd_out   <= dec.mem_rd;
            rd_out       <= rd_next;
        end
    end

    // Store data only moves for stores
    always_ff @(posedge clk_stage or negedge rst) begin
        if (!rst) begin
            store_src <= '0;
        end else if (id_buf_en && dec.is_store) begin
            store_src <= rs2_val;
        end
    end

endmodule

// File: hw/id_stage_top.sv
`timescale 1ns/10ps

module id_stage_top (
    input  logic                  clk_stage,
    input  logic                  rst,
    input  logic                  id_buf_en,
    input  rv_isa_pkg::instr_t    instr,
    input  rv_isa_pkg::data_t     pc,
    input  logic                  pc_taken,
    input  rv_isa_pkg::data_t     regfile1,
    input  rv_isa_pkg::data_t     regfile2,
    input  rv_isa_pkg::reg_idx_t  dest_exe,
    input  rv_isa_pkg::reg_idx_t  dest_mem,
    input  logic                  load_exe,
    input  rv_isa_pkg::data_t     exe_fwd,
    input  rv_isa_pkg::data_t     mem_fwd,
    output rv_isa_pkg::reg_idx_t  rs1_idx,
    output rv_isa_pkg::reg_idx_t  rs2_idx,
    output logic                  id_hold,
    output rv_isa_pkg::data_t     alu_opr1,
    output rv_isa_pkg::data_t     alu_opr2,
    output rv_isa_pkg::data_t     store_src,
    output rv_isa_pkg::data_t     pc_out,
    output logic                  pc_taken_out,
    output id_ctrl_pkg::alu_op_t  alu_op,
    output logic                  sgn,
    output id_ctrl_pkg::br_type_t br_type,
    output logic                  is_branch,
    output logic                  is_jump,
    output logic                  mem_rd_out,
    output rv_isa_pkg::reg_idx_t  rd_out
);

    decode_if          dec_bus ();
    rv_isa_pkg::data_t imm;
    rv_isa_pkg::data_t rs1_val;
    rv_isa_pkg::data_t rs2_val;

    // Register file read addresses, fixed positions in every format
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    opcode_decoder opcode_decoder_inst (
        .instr (instr),
        .dec   (dec_bus)
    );

    imm_gen imm_gen_inst (
        .instr (instr),
        .dec   (dec_bus),
        .imm   (imm)
    );

    // Forwarding and load-use hold
    hazard_forward hazard_forward_inst (
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .dest_exe (dest_exe),
        .dest_mem (dest_mem),
        .load_exe (load_exe),
        .regfile1 (regfile1),
        .regfile2 (regfile2),
        .exe_fwd  (exe_fwd),
        .mem_fwd  (mem_fwd),
        .dec      (dec_bus),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .id_hold  (id_hold)
    );

    id_pipe_reg id_pipe_reg_inst (
        .clk_stage    (clk_stage),
        .rst          (rst),
        .id_buf_en    (id_buf_en),
        .pc           (pc),
        .pc_taken     (pc_taken),
        .instr        (instr),
        .imm          (imm),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .dec          (dec_bus),
        .alu_opr1     (alu_opr1),
        .alu_opr2     (alu_opr2),
        .store_src    (store_src),
        .pc_out       (pc_out),
        .pc_taken_out (pc_taken_out),
        .alu_op       (alu_op),
        .sgn          (sgn),
        .br_type      (br_type),
        .is_branch    (is_branch),
        .is_jump      (is_jump),
        .mem_rd_out   (mem_rd_out),
        .rd_out       (rd_out)
    );

endmodule

// File: hw/imm_gen.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module imm_gen (
    input  rv_isa_pkg::instr_t instr,
    decode_if.imm              dec,
    output rv_isa_pkg::data_t  imm
);

    logic sign;

    // Every format takes its sign from bit 31
    assign sign = instr[31];

    always_comb begin
        if (dec.fmt[rv_isa_pkg::FMT_I]) begin
            imm = {{(`XLEN-12){sign}}, instr[31:20]};
        end else if (dec.fmt[rv_isa_pkg::FMT_S]) begin
            // Offset split around rd position
            imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
        end else if (dec.fmt[rv_isa_pkg::FMT_B]) begin
            // Halfword offset, bit 11 sits in instr[7]
            imm = {{(`XLEN-13){sign}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
        end else if (dec.fmt[rv_isa_pkg::FMT_U]) begin
            imm = {instr[31:12], 12'b0};
        end else if (dec.fmt[rv_isa_pkg::FMT_J]) begin
            imm = {{(`XLEN-21){sign}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};
        end else begin
            // R format and unknown opcodes
            imm = '0;
        end
    end

endmodule

// File: hw/opcode_decoder.sv
`timescale 1ns/10ps

module opcode_decoder (
    input  rv_isa_pkg::instr_t instr,
    decode_if.dec              dec
);

    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_t   funct7;
    logic                  alt;
    id_ctrl_pkg::alu_op_t  arith_op;
    logic                  arith_sgn;
    id_ctrl_pkg::br_type_t arith_br;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = funct7[rv_isa_pkg::F7_ALT_BIT];

    // Shared ALU control for OP and OP_IMM
    // ADDI has no subtract form, so SUB needs the register opcode
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_ADD_SUB:
                arith_op = (alt && opcode == rv_isa_pkg::OP) ?
                           id_ctrl_pkg::ALU_SUB : id_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     arith_op = id_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT,
            rv_isa_pkg::F3_SLTU:    arith_op = id_ctrl_pkg::ALU_SUB;
            rv_isa_pkg::F3_XOR:     arith_op = id_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA:
                arith_op = alt ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      arith_op = id_ctrl_pkg::ALU_OR;
            default:                arith_op = id_ctrl_pkg::ALU_AND;
        endcase
    end

    // Signed compare for SLT, arithmetic shift for SRA
    assign arith_sgn = (funct3 == rv_isa_pkg::F3_SLT) ||
                       (funct3 == rv_isa_pkg::F3_SRL_SRA && alt);

    // Set-less-than reuses the branch compare path
    assign arith_br = (funct3 == rv_isa_pkg::F3_SLT || funct3 == rv_isa_pkg::F3_SLTU) ?
                      id_ctrl_pkg::BR_SLT : id_ctrl_pkg::BR_NONE;

    always_comb begin
        // Defaults match an unknown opcode
        dec.fmt       = '0;
        dec.alu_op    = id_ctrl_pkg::ALU_ADD;
        dec.sgn       = 1'b0;
        dec.br_type   = id_ctrl_pkg::BR_NONE;
        dec.is_branch = 1'b0;
        dec.is_jump   = 1'b0;
        dec.mem_rd    = 1'b0;
        dec.is_store  = 1'b0;
        dec.rd_we     = 1'b1;
        dec.opr1_sel  = id_ctrl_pkg::OPR1_RS1;
        dec.opr2_imm  = 1'b1;
        dec.uses_rs1  = 1'b0;
        dec.uses_rs2  = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                dec.fmt[rv_isa_pkg::FMT_R] = 1'b1;
                dec.alu_op   = arith_op;
                dec.sgn      = arith_sgn;
                dec.br_type  = arith_br;
                dec.opr2_imm = 1'b0;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                dec.fmt[rv_isa_pkg::FMT_I] = 1'b1;
                dec.alu_op   = arith_op;
                dec.sgn      = arith_sgn;
                dec.br_type  = arith_br;
                dec.uses_rs1 = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                dec.fmt[rv_isa_pkg::FMT_U] = 1'b1;
                // Zero plus immediate
                dec.opr1_sel = id_ctrl_pkg::OPR1_ZERO;
            end
            rv_isa_pkg::AUIPC: begin
                dec.fmt[rv_isa_pkg::FMT_U] = 1'b1;
                dec.opr1_sel = id_ctrl_pkg::OPR1_PC;
            end
            rv_isa_pkg::JAL: begin
                dec.fmt[rv_isa_pkg::FMT_J] = 1'b1;
                dec.is_jump  = 1'b1;
                dec.opr1_sel = id_ctrl_pkg::OPR1_PC;
            end
            rv_isa_pkg::JALR: begin
                dec.fmt[rv_isa_pkg::FMT_I] = 1'b1;
                dec.is_jump  = 1'b1;
                dec.uses_rs1 = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                dec.fmt[rv_isa_pkg::FMT_B] = 1'b1;
                dec.is_branch = 1'b1;
                dec.rd_we     = 1'b0;
                dec.opr2_imm  = 1'b0;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
                // Equality through XOR, ordering through the subtractor
                dec.alu_op = funct3[2] ? id_ctrl_pkg::ALU_SUB : id_ctrl_pkg::ALU_XOR;
                dec.sgn    = (funct3 == rv_isa_pkg::F3_BLT) || (funct3 == rv_isa_pkg::F3_BGE);
                case (funct3)
                    rv_isa_pkg::F3_BEQ:  dec.br_type = id_ctrl_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE:  dec.br_type = id_ctrl_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT,
                    rv_isa_pkg::F3_BLTU: dec.br_type = id_ctrl_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE,
                    rv_isa_pkg::F3_BGEU: dec.br_type = id_ctrl_pkg::BR_GE;
                    default:             dec.br_type = id_ctrl_pkg::BR_NONE;
                endcase
            end
            rv_isa_pkg::LOAD: begin
                dec.fmt[rv_isa_pkg::FMT_I] = 1'b1;
                dec.mem_rd   = 1'b1;
                dec.uses_rs1 = 1'b1;
            end
            rv_isa_pkg::STORE: begin
                dec.fmt[rv_isa_pkg::FMT_S] = 1'b1;
                dec.is_store = 1'b1;
                dec.rd_we    = 1'b0;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            default: begin
                dec.fmt = '0;
            end
        endcase
    end

endmodule

// File: hw/rv_isa_pkg.sv
`include "id_defines.svh"

package rv_isa_pkg;

    // Raw instruction word and its fields
    typedef logic [31:0]             instr_t;
    typedef logic [`XLEN-1:0]        data_t;
    typedef logic [`REG_IDX_W-1:0]   reg_idx_t;
    typedef logic [6:0]              opcode_t;
    typedef logic [2:0]              funct3_t;
    typedef logic [6:0]              funct7_t;

    // One-hot format, one bit per encoding
    typedef logic [5:0] fmt_t;

    localparam int FMT_R = 0;
    localparam int FMT_I = 1;
    localparam int FMT_S = 2;
    localparam int FMT_B = 3;
    localparam int FMT_U = 4;
    localparam int FMT_J = 5;

    // RV32I base opcodes
    localparam opcode_t OP     = 7'b0110011;
    localparam opcode_t OP_IMM = 7'b0010011;
    localparam opcode_t LUI    = 7'b0110111;
    localparam opcode_t AUIPC  = 7'b0010111;
    localparam opcode_t JAL    = 7'b1101111;
    localparam opcode_t JALR   = 7'b1100111;
    localparam opcode_t BRANCH = 7'b1100011;
    localparam opcode_t LOAD   = 7'b0000011;
    localparam opcode_t STORE  = 7'b0100011;

    // Integer funct3 for OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // funct7 bit that selects SUB and SRA
    localparam int F7_ALT_BIT = 5;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module tb_id_stage \
    -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: sources.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/decode_if.sv
hw/opcode_decoder.sv
hw/imm_gen.sv
hw/hazard_forward.sv
hw/id_pipe_reg.sv
hw/id_stage_top.sv
testbench/tb_id_stage.sv

// File: testbench/id_trace.txt
# name en instr pc rnd(bit0 rf1, bit1 rf2 random) rf1 rf2 dexe dmem load_exe exe_fwd mem_fwd
# then expected: hold alu_op sgn br_type flags(mem_rd,branch,jump) opr1 opr2 store_src rd
add      1 002081b3 0100 0 1111 2222 00 00 0 eeee dddd  0 01 0 0 0 00001111 00002222 0    03
sub      1 402081b3 0104 0 1111 2222 00 00 0 eeee dddd  0 03 0 0 0 00001111 00002222 0    03
sll      1 002091b3 0108 0 1111 2222 00 00 0 eeee dddd  0 20 0 0 0 00001111 00002222 0    03
slt      1 0020a1b3 010c 0 1111 2222 00 00 0 eeee dddd  0 03 1 8 0 00001111 00002222 0    03
sltu     1 0020b1b3 0110 0 1111 2222 00 00 0 eeee dddd  0 03 0 8 0 00001111 00002222 0    03
xor      1 0020c1b3 0114 0 1111 2222 00 00 0 eeee dddd  0 10 0 0 0 00001111 00002222 0    03
srl      1 0020d1b3 0118 0 1111 2222 00 00 0 eeee dddd  0 40 0 0 0 00001111 00002222 0    03
sra      1 4020d1b3 011c 0 1111 2222 00 00 0 eeee dddd  0 80 1 0 0 00001111 00002222 0    03
or       1 0020e1b3 0120 0 1111 2222 00 00 0 eeee dddd  0 08 0 0 0 00001111 00002222 0    03
and      1 0020f1b3 0124 0 1111 2222 00 00 0 eeee dddd  0 04 0 0 0 00001111 00002222 0    03
addi     1 fff08293 0128 2 1111 0    00 00 0 eeee dddd  0 01 0 0 0 00001111 ffffffff 0    05
slti     1 7ff0a293 012c 2 1111 0    00 00 0 eeee dddd  0 03 1 8 0 00001111 000007ff 0    05
sltiu    1 8000b293 0130 2 1111 0    00 00 0 eeee dddd  0 03 0 8 0 00001111 fffff800 0    05
xori     1 1230c293 0134 2 1111 0    00 00 0 eeee dddd  0 10 0 0 0 00001111 00000123 0    05
ori      1 ff00e293 0138 2 1111 0    00 00 0 eeee dddd  0 08 0 0 0 00001111 fffffff0 0    05
andi     1 0f00f293 013c 2 1111 0    00 00 0 eeee dddd  0 04 0 0 0 00001111 000000f0 0    05
slli     1 00309293 0140 2 1111 0    00 00 0 eeee dddd  0 20 0 0 0 00001111 00000003 0    05
srli     1 0040d293 0144 2 1111 0    00 00 0 eeee dddd  0 40 0 0 0 00001111 00000004 0    05
srai     1 4070d293 0148 2 1111 0    00 00 0 eeee dddd  0 80 1 0 0 00001111 00000407 0    05
lui      1 123453b7 014c 3 0    0    00 00 0 eeee dddd  0 01 0 0 0 00000000 12345000 0    07
auipc    1 80000397 2000 3 0    0    00 00 0 eeee dddd  0 01 0 0 0 00002000 80000000 0    07
jal      1 010000ef 3000 3 0    0    00 00 0 eeee dddd  0 01 0 0 1 00003000 00000010 0    01
jal_neg  1 ff9ff06f 3004 3 0    0    00 00 0 eeee dddd  0 01 0 0 1 00003004 fffffff8 0    00
jalr     1 004300e7 3008 2 1111 0    00 00 0 eeee dddd  0 01 0 0 1 00001111 00000004 0    01
lw       1 ff412503 300c 2 1111 0    00 00 0 eeee dddd  0 01 0 0 4 00001111 fffffff4 0    0a
sw       1 0020a423 3010 0 1111 2222 00 00 0 eeee dddd  0 01 0 0 0 00001111 00000008 2222 00
sw_neg   1 fe20ae23 3014 0 1111 3333 00 00 0 eeee dddd  0 01 0 0 0 00001111 fffffffc 3333 00
beq      1 00208463 3018 0 1111 2222 00 00 0 eeee dddd  0 10 0 5 2 00001111 00002222 3333 00
bne      1 00209463 301c 0 1111 2222 00 00 0 eeee dddd  0 10 0 1 2 00001111 00002222 3333 00
blt      1 0020c463 3020 0 1111 2222 00 00 0 eeee dddd  0 03 1 2 2 00001111 00002222 3333 00
bge      1 0020d463 3024 0 1111 2222 00 00 0 eeee dddd  0 03 1 6 2 00001111 00002222 3333 00
bltu     1 0020e463 3028 0 1111 2222 00 00 0 eeee dddd  0 03 0 2 2 00001111 00002222 3333 00
bgeu     1 0020f463 302c 0 1111 2222 00 00 0 eeee dddd  0 03 0 6 2 00001111 00002222 3333 00
fwd_em   1 002081b3 3030 3 0    0    01 02 0 eeee dddd  0 01 0 0 0 0000eeee 0000dddd 3333 03
fwd_both 1 002081b3 3034 2 1111 0    02 02 0 eeee dddd  0 01 0 0 0 00001111 0000eeee 3333 03
x0_src   1 002001b3 3038 1 0    2222 00 00 0 eeee dddd  0 01 0 0 0 00000000 00002222 3333 03
sw_fwd   1 0020a423 303c 2 1111 0    00 02 0 eeee dddd  0 01 0 0 0 00001111 00000008 dddd 00
ld_use   1 002081b3 3040 1 0    2222 01 00 1 eeee dddd  1 01 0 0 0 0000eeee 00002222 dddd 03
no_use   1 fff08293 3044 2 1111 0    1f 00 1 eeee dddd  0 01 0 0 0 00001111 ffffffff dddd 05
x0_load  1 002001b3 3048 1 0    2222 00 00 1 eeee dddd  0 01 0 0 0 00000000 00002222 dddd 03
keep     0 0020a423 304c 0 1111 2222 02 00 1 eeee dddd  1 01 0 0 0 00000000 00002222 dddd 03

// File: testbench/tb_id_stage.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module tb_id_stage;

    // Limits for the reset wait and the trace loop
    localparam int RESET_TIMEOUT = 50;
    localparam int MAX_VECTORS   = 400;

    logic                  clk_stage;
    logic                  rst;
    logic                  id_buf_en;
    rv_isa_pkg::instr_t    instr;
    rv_isa_pkg::data_t     pc;
    logic                  pc_taken;
    rv_isa_pkg::data_t     regfile1;
    rv_isa_pkg::data_t     regfile2;
    rv_isa_pkg::reg_idx_t  dest_exe;
    rv_isa_pkg::reg_idx_t  dest_mem;
    logic                  load_exe;
    rv_isa_pkg::data_t     exe_fwd;
    rv_isa_pkg::data_t     mem_fwd;
    rv_isa_pkg::reg_idx_t  rs1_idx;
    rv_isa_pkg::reg_idx_t  rs2_idx;
    logic                  id_hold;
    rv_isa_pkg::data_t     alu_opr1;
    rv_isa_pkg::data_t     alu_opr2;
    rv_isa_pkg::data_t     store_src;
    rv_isa_pkg::data_t     pc_out;
    logic                  pc_taken_out;
    id_ctrl_pkg::alu_op_t  alu_op;
    logic                  sgn;
    id_ctrl_pkg::br_type_t br_type;
    logic                  is_branch;
    logic                  is_jump;
    logic                  mem_rd_out;
    rv_isa_pkg::reg_idx_t  rd_out;

    // Current trace vector, stimulus fields
    logic [8*12-1:0] test_name;
    logic [31:0]     in_en, in_instr, in_pc, in_rnd;
    logic [31:0]     in_rf1, in_rf2, in_dexe, in_dmem;
    logic [31:0]     in_ld, in_efwd, in_mfwd;
    // Expected results of the same vector
    logic [31:0]     exp_hold, exp_op, exp_sgn, exp_br, exp_flags;
    logic [31:0]     exp_opr1, exp_opr2, exp_store, exp_rd;
    logic [8*128-1:0] line_buf;

    // PC and prediction flag last accepted by the stage
    rv_isa_pkg::data_t held_pc;
    logic              held_taken;

    id_stage_top id_stage_top_inst (.*);

    initial begin
        clk_stage = 1'b0;
        forever #50 clk_stage = ~clk_stage;
    end

    // Reset held for ten cycles, released off the edge
    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk_stage);
        #5 rst = 1'b1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input logic [8*12-1:0] name, input string signal,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] test %0s, %0s: expected %h, actual %h",
                     name, signal, expected, actual);
            abort_run("Output mismatch");
        end
    endtask

    task automatic confirm_reset_state();
        test_name = "reset";
        check_value(test_name, "alu_opr1", 32'h0, alu_opr1);
        check_value(test_name, "alu_opr2", 32'h0, alu_opr2);
        check_value(test_name, "store_src", 32'h0, store_src);
        check_value(test_name, "pc_out", 32'h0, pc_out);
        check_value(test_name, "pc_taken_out", 32'h0, 32'(pc_taken_out));
        check_value(test_name, "alu_op", 32'h0, 32'(alu_op));
        check_value(test_name, "sgn", 32'h0, 32'(sgn));
        check_value(test_name, "br_type", 32'h0, 32'(br_type));
        check_value(test_name, "flags", 32'h0, 32'({mem_rd_out, is_branch, is_jump}));
        check_value(test_name, "rd_out", 32'h0, 32'(rd_out));
    endtask

    task automatic drive_vector();
        id_buf_en = in_en[0];
        instr     = in_instr;
        pc        = in_pc;
        // Prediction flag follows a PC bit so it toggles between vectors
        pc_taken  = in_pc[2];
        // Don't-care register reads get random filler
        regfile1  = in_rnd[0] ? $urandom : in_rf1;
        regfile2  = in_rnd[1] ? $urandom : in_rf2;
        dest_exe  = in_dexe[`REG_IDX_W-1:0];
        dest_mem  = in_dmem[`REG_IDX_W-1:0];
        load_exe  = in_ld[0];
        exe_fwd   = in_efwd;
        mem_fwd   = in_mfwd;
    endtask

    // Entered 2 ns after an edge, leaves 2 ns after the next one
    task automatic run_vector();
        #3;
        drive_vector();
        // Stage keeps the old PC while the enable is low
        if (in_en[0]) begin
            held_pc    = in_pc;
            held_taken = in_pc[2];
        end
        // Hold and register indices are combinational, sample mid-cycle
        @(negedge clk_stage);
        check_value(test_name, "id_hold", exp_hold, 32'(id_hold));
        check_value(test_name, "rs1_idx", 32'(in_instr[19:15]), 32'(rs1_idx));
        check_value(test_name, "rs2_idx", 32'(in_instr[24:20]), 32'(rs2_idx));
        @(posedge clk_stage);
        #2;
        check_value(test_name, "alu_op", exp_op, 32'(alu_op));
        check_value(test_name, "sgn", exp_sgn, 32'(sgn));
        check_value(test_name, "br_type", exp_br, 32'(br_type));
        // Flags packed as mem_rd, branch, jump
        check_value(test_name, "flags", exp_flags, 32'({mem_rd_out, is_branch, is_jump}));
        check_value(test_name, "alu_opr1", exp_opr1, alu_opr1);
        check_value(test_name, "alu_opr2", exp_opr2, alu_opr2);
        check_value(test_name, "store_src", exp_store, store_src);
        check_value(test_name, "rd_out", exp_rd, 32'(rd_out));
        check_value(test_name, "pc_out", held_pc, pc_out);
        check_value(test_name, "pc_taken_out", 32'(held_taken), 32'(pc_taken_out));
    endtask

    initial begin : main_flow
        int          fd;
        int          code;
        int          cycles;
        int          num_vectors;
        logic        trace_done;

        void'($urandom(32'h377bfb8b));
        id_buf_en  = 1'b0;
        instr      = '0;
        pc         = '0;
        pc_taken   = 1'b0;
        regfile1   = '0;
        regfile2   = '0;
        dest_exe   = '0;
        dest_mem   = '0;
        load_exe   = 1'b0;
        exe_fwd    = '0;
        mem_fwd    = '0;
        held_pc    = '0;
        held_taken = 1'b0;

        fd = $fopen("testbench/id_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open testbench/id_trace.txt");
        end

        // Wait for reset release, bounded
        cycles = 0;
        while (rst !== 1'b1) begin
            if (cycles == RESET_TIMEOUT) begin
                abort_run("Timeout waiting for reset release");
            end
            @(posedge clk_stage);
            cycles++;
        end
        #2;
        confirm_reset_state();

        // One vector per cycle until the trace runs out
        num_vectors = 0;
        trace_done  = 1'b0;
        while (!trace_done) begin
            code = $fscanf(fd, "%s", test_name);
            if (code != 1) begin
                trace_done = 1'b1;
            end else if (test_name == "#") begin
                // Column description line
                code = $fgets(line_buf, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               in_en, in_instr, in_pc, in_rnd, in_rf1, in_rf2, in_dexe,
                               in_dmem, in_ld, in_efwd, in_mfwd, exp_hold, exp_op, exp_sgn,
                               exp_br, exp_flags, exp_opr1, exp_opr2, exp_store, exp_rd);
                if (code != 20) begin
                    abort_run("Malformed line in trace file");
                end
                num_vectors++;
                if (num_vectors > MAX_VECTORS) begin
                    abort_run("Timeout, trace did not end within the vector limit");
                end
                run_vector();
            end
        end
        $fclose(fd);

        if (num_vectors == 0) begin
            abort_run("Trace file held no vectors");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
